//--- src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    localparam logic [dataWidth-1:0]    resetVector = 32'hBFC00000;
    localparam logic [dataWidth-1:0]    haltAddress = 32'h00000000;
    localparam logic [regAddrWidth-1:0] linkReg     = 5'd31; // $ra

    // primary opcodes, instruction[31:26]
    typedef enum logic [5:0] {
        OP_R_TYPE = 6'b000000,
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LW     = 6'b100011,
        OP_SW     = 6'b101011
    } opCodeT;

    // R-type function field, instruction[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } fnCodeT;

    typedef enum logic [3:0] {
        ALU_AND, ALU_OR, ALU_XOR, ALU_LUI,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSA
    } aluOpT;

    typedef enum logic [2:0] {
        CLASS_ALU, CLASS_LOAD, CLASS_STORE, CLASS_BEQ,
        CLASS_BNE, CLASS_JUMP, CLASS_JUMPREG, CLASS_NOP
    } instrClassT;

    typedef enum logic [2:0] {
        S_FETCH     = 3'b000,
        S_DECODE    = 3'b001,
        S_EXECUTE   = 3'b010,
        S_MEMORY    = 3'b011,
        S_WRITEBACK = 3'b100,
        S_HALTED    = 3'b111
    } cpuStateT;

endpackage

`default_nettype wire

//--- src/regFile.sv
`default_nettype none

module regFile
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB,
    input  logic                    writeEnable,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]    regV0
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    // $zero is hardwired, whatever the array holds
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    assign regV0 = regs[2]; // $v0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`default_nettype none

module alu
    import mipsPkg::*;
(
    input  aluOpT                aluOp,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic [4:0]           shamt,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    always_comb begin
        case (aluOp)
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_LUI: begin
                result = {b[15:0], 16'h0000}; // immediate into the upper half
            end
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                result = (a < b) ? 32'd1 : 32'd0;
            end
            // constant shifts act on rt, which arrives on b
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_SRL: begin
                result = b >> shamt;
            end
            ALU_SRA: begin
                result = $signed(b) >>> shamt;
            end
            ALU_PASSA: begin
                result = a; // JR target
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // BEQ/BNE run a subtract and look at this
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`default_nettype none

module instrDecoder
    import mipsPkg::*;
(
    input  logic [dataWidth-1:0]    instruction,
    output aluOpT                   aluOp,
    output logic [dataWidth-1:0]    immediate,
    output logic                    useImm,
    output instrClassT              instrClass,
    output logic                    regWrite,
    output logic [regAddrWidth-1:0] writeAddr
);

    logic [5:0]              opField;
    logic [5:0]              fnField;
    logic [regAddrWidth-1:0] rtField;
    logic [regAddrWidth-1:0] rdField;
    logic [15:0]             imm16;

    assign opField = instruction[31:26];
    assign rtField = instruction[20:16];
    assign rdField = instruction[15:11];
    assign imm16   = instruction[15:0];
    assign fnField = instruction[5:0];

    always_comb begin
        // unknown encodings fall through as no-ops
        aluOp      = ALU_ADD;
        useImm     = 1'b0;
        instrClass = CLASS_NOP;
        regWrite   = 1'b0;
        immediate  = {{16{imm16[15]}}, imm16};

        case (opField)
            OP_R_TYPE: begin
                instrClass = CLASS_ALU;
                regWrite   = 1'b1;
                case (fnField)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_JR: begin
                        aluOp      = ALU_PASSA;
                        instrClass = CLASS_JUMPREG;
                        regWrite   = 1'b0;
                    end
                    default: begin
                        instrClass = CLASS_NOP;
                        regWrite   = 1'b0;
                    end
                endcase
            end
            OP_J: instrClass = CLASS_JUMP;
            OP_JAL: begin
                instrClass = CLASS_JUMP;
                regWrite   = 1'b1; // link into $ra
            end
            OP_BEQ: begin
                aluOp      = ALU_SUB;
                instrClass = CLASS_BEQ;
            end
            OP_BNE: begin
                aluOp      = ALU_SUB;
                instrClass = CLASS_BNE;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                useImm     = 1'b1;
                instrClass = CLASS_ALU;
                regWrite   = 1'b1;
                case (opField)
                    OP_SLTI:  aluOp = ALU_SLT;
                    OP_SLTIU: aluOp = ALU_SLTU;
                    OP_ANDI:  aluOp = ALU_AND;
                    OP_ORI:   aluOp = ALU_OR;
                    OP_XORI:  aluOp = ALU_XOR;
                    OP_LUI:   aluOp = ALU_LUI;
                    default:  aluOp = ALU_ADD;
                endcase
                // logical immediates are zero-extended
                if (opField == OP_ANDI || opField == OP_ORI || opField == OP_XORI) begin
                    immediate = {16'h0000, imm16};
                end
            end
            OP_LW: begin
                useImm     = 1'b1;
                instrClass = CLASS_LOAD;
                regWrite   = 1'b1;
            end
            OP_SW: begin
                useImm     = 1'b1;
                instrClass = CLASS_STORE;
            end
            default: ;
        endcase
    end

    assign writeAddr = (opField == OP_R_TYPE) ? rdField :
                       (opField == OP_JAL)    ? linkReg : rtField;

endmodule

`default_nettype wire

//--- src/cpuController.sv
`default_nettype none

module cpuController
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    output logic                    active,
    output logic [dataWidth-1:0]    address,
    output logic                    read,
    output logic                    write,
    input  logic                    waitrequest,
    output logic [dataWidth-1:0]    writedata,
    output logic [3:0]              byteenable,
    input  logic [dataWidth-1:0]    readdata,
    output logic [dataWidth-1:0]    instruction,
    input  instrClassT              instrClass,
    input  logic                    regWrite,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0]    regReadA,
    input  logic [dataWidth-1:0]    regReadB,
    input  logic [dataWidth-1:0]    aluResult,
    input  logic                    aluZero,
    output logic                    rfWriteEnable,
    output logic [regAddrWidth-1:0] rfWriteAddr,
    output logic [dataWidth-1:0]    rfWriteData
);

    cpuStateT             state;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] pcPlus8;
    logic [dataWidth-1:0] branchOffset;
    logic [dataWidth-1:0] branchTarget;
    logic                 branchTaken;   // current instruction jumps
    logic                 branchPending; // delay slot in flight
    logic                 branchCond;
    logic                 memAccess;

    // bus words come in reversed byte order
    function automatic logic [dataWidth-1:0] byteSwap(input logic [dataWidth-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign pcPlus4      = pc + 32'd4;
    assign pcPlus8      = pc + 32'd8;
    assign branchOffset = {{14{instruction[15]}}, instruction[15:0], 2'b00};
    assign branchCond   = (instrClass == CLASS_BEQ && aluZero) ||
                          (instrClass == CLASS_BNE && !aluZero);

    assign read = (state == S_FETCH && pc != haltAddress) ||
                  (state == S_MEMORY && instrClass == CLASS_LOAD);
    assign write = (state == S_MEMORY && instrClass == CLASS_STORE);
    assign memAccess = read || write;

    assign address    = (state == S_FETCH) ? pc : {aluResult[31:2], 2'b00};
    assign writedata  = byteSwap(regReadB);
    assign byteenable = memAccess ? 4'b1111 : 4'b0000; // whole words only

    // register write port, live during writeback only
    assign rfWriteEnable = (state == S_WRITEBACK) && regWrite;
    assign rfWriteAddr   = writeAddr;
    assign rfWriteData   = (instrClass == CLASS_LOAD) ? byteSwap(readdata) :
                           (instrClass == CLASS_JUMP) ? pcPlus8 : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= S_FETCH;
            pc            <= resetVector;
            active        <= 1'b1;
            branchTaken   <= 1'b0;
            branchPending <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (pc == haltAddress) begin
                        active <= 1'b0;
                        state  <= S_HALTED;
                    end else if (!waitrequest) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: state <= S_EXECUTE;
                S_EXECUTE: begin
                    if (instrClass == CLASS_JUMP || instrClass == CLASS_JUMPREG) begin
                        branchTaken <= 1'b1;
                    end
                    state <= S_MEMORY;
                end
                S_MEMORY: begin
                    if (branchCond) begin
                        branchTaken <= 1'b1;
                    end
                    if (!memAccess || !waitrequest) begin
                        state <= S_WRITEBACK;
                    end
                end
                S_WRITEBACK: begin
                    // taken jump steps into its delay slot, the slot then goes to the target
                    if (branchTaken) begin
                        branchTaken   <= 1'b0;
                        branchPending <= 1'b1;
                        pc            <= pcPlus4;
                    end else if (branchPending) begin
                        branchPending <= 1'b0;
                        pc            <= branchTarget;
                    end else begin
                        pc <= pcPlus4;
                    end
                    state <= S_FETCH;
                end
                S_HALTED: ; // stays here until reset
                default: state <= S_HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            instruction <= byteSwap(readdata);
        end
        if (state == S_EXECUTE) begin
            if (instrClass == CLASS_JUMP) begin
                branchTarget <= {pcPlus4[31:28], instruction[25:0], 2'b00};
            end else if (instrClass == CLASS_JUMPREG) begin
                branchTarget <= regReadA;
            end
        end
        if (state == S_MEMORY && branchCond) begin
            branchTarget <= pcPlus4 + branchOffset;
        end
    end

endmodule

`default_nettype wire

//--- src/mipsCpuBus.sv
`default_nettype none

module mipsCpuBus
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    output logic                 active,
    output logic [dataWidth-1:0] regV0,
    output logic [dataWidth-1:0] address,
    output logic                 read,
    output logic                 write,
    input  logic                 waitrequest,
    output logic [dataWidth-1:0] writedata,
    output logic [3:0]           byteenable,
    input  logic [dataWidth-1:0] readdata
);

    logic [dataWidth-1:0]    instruction;
    aluOpT                   aluOp;
    logic [dataWidth-1:0]    immediate;
    logic                    useImm;
    instrClassT              instrClass;
    logic                    regWrite;
    logic [regAddrWidth-1:0] writeAddr;
    logic [dataWidth-1:0]    regReadA;
    logic [dataWidth-1:0]    regReadB;
    logic [dataWidth-1:0]    aluB;
    logic [dataWidth-1:0]    aluResult;
    logic                    aluZero;
    logic                    rfWriteEnable;
    logic [regAddrWidth-1:0] rfWriteAddr;
    logic [dataWidth-1:0]    rfWriteData;

    assign aluB = useImm ? immediate : regReadB; // I-type operand select

    cpuController cpuController_inst (
        .clk(clk), .reset(reset), .active(active),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .instruction(instruction), .instrClass(instrClass), .regWrite(regWrite),
        .writeAddr(writeAddr), .regReadA(regReadA), .regReadB(regReadB),
        .aluResult(aluResult), .aluZero(aluZero), .rfWriteEnable(rfWriteEnable),
        .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData)
    );

    instrDecoder instrDecoder_inst (
        .instruction(instruction), .aluOp(aluOp), .immediate(immediate), .useImm(useImm),
        .instrClass(instrClass), .regWrite(regWrite), .writeAddr(writeAddr)
    );

    alu alu_inst (
        .aluOp(aluOp), .a(regReadA), .b(aluB), .shamt(instruction[10:6]),
        .result(aluResult), .zero(aluZero)
    );

    // rs and rt come straight from the instruction register
    regFile regFile_inst (
        .clk(clk), .reset(reset),
        .readAddrA(instruction[25:21]), .readAddrB(instruction[20:16]),
        .readDataA(regReadA), .readDataB(regReadB),
        .writeEnable(rfWriteEnable), .writeAddr(rfWriteAddr), .writeData(rfWriteData),
        .regV0(regV0)
    );

endmodule

`default_nettype wire

//--- tests/busMemory.sv
`default_nettype none

module busMemory
    import mipsPkg::dataWidth;
#(
    parameter int unsigned stallSeed = 32'd1
)
(
    input  logic                 clk,
    input  logic                 randomWait,
    input  logic [dataWidth-1:0] address,
    input  logic                 read,
    input  logic                 write,
    input  logic [dataWidth-1:0] writedata,
    input  logic [3:0]           byteenable,
    output logic                 waitrequest,
    output logic [dataWidth-1:0] readdata
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [dataWidth-1:0] mem [logic [dataWidth-1:0]]; // bus words, byte-swapped
    logic [dataWidth-1:0] nextData;
    logic [dataWidth-1:0] mergedWord;

    // unwritten words read back as a pattern built from the address
    function automatic logic [dataWidth-1:0] rawWord(input logic [dataWidth-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a[15:0], a[31:16]} ^ 32'h5A5A5A5A;
    endfunction

    task automatic loadWord(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] w);
        mem[a] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endtask

    task automatic clear();
        mem.delete();
    endtask

    // requests are taken at the edge, responses appear 1 ns later
    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
        nextData    = '0;
        void'($urandom(stallSeed));
        forever begin
            @(posedge clk);
            if (read && !waitrequest) begin
                nextData = rawWord(address);
            end
            if (write && !waitrequest) begin
                mergedWord = rawWord(address);
                for (int i = 0; i < 4; i++) begin
                    if (byteenable[i]) begin
                        mergedWord[8*i +: 8] = writedata[8*i +: 8]; // lane i of the bus word
                    end
                end
                mem[address] = mergedWord;
            end
            #1;
            readdata    = nextData;
            waitrequest = randomWait && ($urandom % 2 == 1);
        end
    end

endmodule

`default_nettype wire

//--- tests/tbMipsCpuBus.sv
`default_nettype none

module tbMipsCpuBus
    import mipsPkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int cycleLimit = 20000; // longest program is well under 60 instructions
    localparam int unsigned randomSeed = 32'hf9d25051;
    localparam logic [4:0] zeroReg = 5'd0;
    localparam logic [4:0] v0Reg   = 5'd2;
    localparam logic [4:0] t0 = 5'd8;
    localparam logic [4:0] t1 = 5'd9;
    localparam logic [4:0] t2 = 5'd10;
    localparam logic [4:0] t3 = 5'd11;
    localparam logic [4:0] t4 = 5'd12;
    localparam logic [4:0] t5 = 5'd13;
    localparam logic [4:0] t6 = 5'd14;
    localparam logic [4:0] t7 = 5'd15;
    localparam logic [4:0] raReg = 5'd31;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] regV0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    logic        stallEnable;

    int          errorCount = 0;
    int          cycleCount = 0;
    int          storeCount = 0;
    logic [31:0] lastStoreAddr;
    logic [31:0] lastStoreData;
    logic        holdPending = 1'b0;
    logic [31:0] heldAddr;
    logic [31:0] heldData;
    logic        heldRead;
    logic        heldWrite;
    logic [31:0] prog [$];

    mipsCpuBus mipsCpuBus_inst (
        .clk(clk), .reset(reset), .active(active), .regV0(regV0),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    busMemory #(.stallSeed(randomSeed)) busMemory_inst (
        .clk(clk), .randomWait(stallEnable), .address(address), .read(read),
        .write(write), .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run reached %0d cycles without finishing", cycleCount);
            $display("Errors: %0d", errorCount);
            $display("Test failed");
            $finish;
        end
    end

    // bus watcher, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (reset) begin
            holdPending = 1'b0;
        end else begin
            if (holdPending) begin
                assert (address == heldAddr && read == heldRead && write == heldWrite &&
                        (!write || writedata == heldData)) else begin
                    errorCount++;
                    $display("request at %h changed while waitrequest was high", heldAddr);
                end
            end
            holdPending = (read || write) && waitrequest;
            heldAddr    = address;
            heldData    = writedata;
            heldRead    = read;
            heldWrite   = write;
            if (write && !waitrequest) begin
                lastStoreAddr = address;
                lastStoreData = writedata;
                storeCount++;
            end
            // every kept access is a whole word
            assert (!(read || write) || byteenable === 4'hF) else begin
                errorCount++;
                $display("Fail byteenable: got %h expected %h", byteenable, 4'hF);
            end
            assert (!(active === 1'b0 && read)) else begin
                errorCount++;
                $display("read issued at %h after the CPU halted", address);
            end
        end
    end

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] swapBytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic pulseReset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic waitHalt();
        int n;
        n = 0;
        while (active !== 1'b0 && n < 5000) begin
            @(negedge clk);
            n++;
        end
        assert (active === 1'b0) else begin
            errorCount++;
            $display("CPU did not halt within 5000 cycles");
        end
        repeat (5) @(negedge clk); // watcher keeps looking for stray reads
    endtask

    task automatic runProgram();
        busMemory_inst.clear();
        foreach (prog[i]) begin
            busMemory_inst.loadWord(resetVector + 32'(4 * i), prog[i]);
        end
        storeCount = 0;
        pulseReset();
        waitHalt();
    endtask

    task automatic resetAndFirstFetch();
        prog = {rType(zeroReg, zeroReg, zeroReg, 5'd0, FN_JR), 32'h0};
        busMemory_inst.clear();
        busMemory_inst.loadWord(resetVector, prog[0]);
        busMemory_inst.loadWord(resetVector + 32'd4, prog[1]);
        pulseReset();
        @(negedge clk);
        checkValue("active", {31'b0, active}, 32'd1);
        checkValue("read", {31'b0, read}, 32'd1);
        checkValue("address", address, resetVector);
        checkValue("byteenable", {28'b0, byteenable}, 32'hF);
        checkValue("write", {31'b0, write}, 32'd0);
        waitHalt();
    endtask

    task automatic aluProgram();
        logic [31:0] r8, r9, r10, r11, r12, r13, r14, r15, exp;
        prog = {};
        prog.push_back(iType(OP_ADDIU, zeroReg, t0, 16'hFFF9));
        prog.push_back(iType(OP_ORI, zeroReg, t1, 16'h1234));
        prog.push_back(iType(OP_LUI, zeroReg, t2, 16'h8000));
        prog.push_back(rType(t1, t0, t3, 5'd0, FN_SUBU));
        prog.push_back(rType(t0, t1, t4, 5'd0, FN_SLT));
        prog.push_back(rType(t0, t1, t5, 5'd0, FN_SLTU));
        prog.push_back(rType(zeroReg, t3, t6, 5'd4, FN_SLL));
        prog.push_back(rType(zeroReg, t2, t7, 5'd8, FN_SRA));
        prog.push_back(rType(t6, t7, v0Reg, 5'd0, FN_XOR));
        prog.push_back(rType(v0Reg, t4, v0Reg, 5'd0, FN_ADDU));
        prog.push_back(rType(v0Reg, t5, v0Reg, 5'd0, FN_ADDU));
        prog.push_back(rType(zeroReg, zeroReg, zeroReg, 5'd0, FN_JR));
        prog.push_back(32'h0);
        runProgram();
        r8  = {16'hFFFF, 16'hFFF9};          // -7 sign-extended
        r9  = 32'h00001234;
        r10 = {16'h8000, 16'h0000};
        r11 = r9 - r8;
        r12 = ($signed(r8) < $signed(r9)) ? 32'd1 : 32'd0;
        r13 = (r8 < r9) ? 32'd1 : 32'd0;
        r14 = r11 << 4;
        r15 = $signed(r10) >>> 8;
        exp = (r14 ^ r15) + r12 + r13;
        checkValue("regV0", regV0, exp);
    endtask

    task automatic loadStoreTest(input logic withStalls);
        logic [31:0] value, addr;
        stallEnable = withStalls;
        prog = {};
        prog.push_back(iType(OP_LUI, zeroReg, t0, 16'h1000));
        prog.push_back(iType(OP_LUI, zeroReg, t1, 16'hCAFE));
        prog.push_back(iType(OP_ORI, t1, t1, 16'hBEEF));
        prog.push_back(iType(OP_SW, t0, t1, 16'd8));
        prog.push_back(iType(OP_LW, t0, v0Reg, 16'd8));
        prog.push_back(rType(zeroReg, zeroReg, zeroReg, 5'd0, FN_JR));
        prog.push_back(32'h0);
        runProgram();
        stallEnable = 1'b0;
        value = {16'hCAFE, 16'hBEEF};
        addr  = {16'h1000, 16'h0000} + 32'd8;
        checkValue("storeCount", storeCount, 32'd1);
        checkValue("store address", lastStoreAddr, addr);
        checkValue("writedata", lastStoreData, swapBytes(value));
        checkValue("memory word", busMemory_inst.rawWord(addr), swapBytes(value));
        checkValue("regV0", regV0, value);
    endtask

    task automatic branchProgram();
        prog = {};
        prog.push_back(iType(OP_ADDIU, zeroReg, v0Reg, 16'd1));
        prog.push_back(iType(OP_ADDIU, zeroReg, t0, 16'd5));
        prog.push_back(iType(OP_BEQ, t0, t0, 16'd2));         // to word 5
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'd2)); // delay slot
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'd4)); // skipped
        prog.push_back(iType(OP_BNE, t0, t0, 16'd3));         // never taken
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'd8));
        prog.push_back(jType(OP_J, resetVector + 32'd40));
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'd16));
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'd32));
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'd64));
        prog.push_back(rType(zeroReg, zeroReg, zeroReg, 5'd0, FN_JR));
        prog.push_back(32'h0);
        runProgram();
        checkValue("regV0", regV0, 32'd1 + 32'd2 + 32'd8 + 32'd16 + 32'd64);
    endtask

    task automatic callReturnProgram();
        logic [31:0] link;
        prog = {};
        prog.push_back(jType(OP_JAL, resetVector + 32'd32));
        prog.push_back(iType(OP_ADDIU, zeroReg, v0Reg, 16'd1));
        prog.push_back(rType(v0Reg, raReg, v0Reg, 5'd0, FN_XOR)); // return lands here
        prog.push_back(rType(zeroReg, zeroReg, zeroReg, 5'd0, FN_JR));
        repeat (4) prog.push_back(32'h0);
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'h0100));
        prog.push_back(rType(raReg, zeroReg, zeroReg, 5'd0, FN_JR));
        prog.push_back(iType(OP_ADDIU, v0Reg, v0Reg, 16'h0010));
        runProgram();
        link = resetVector + 32'd8;
        checkValue("regV0", regV0, (32'd1 + 32'h100 + 32'h10) ^ link);
        checkValue("active", {31'b0, active}, 32'd0);
    endtask

    initial begin
        reset       = 1'b1;
        stallEnable = 1'b0;
        resetAndFirstFetch();
        aluProgram();
        loadStoreTest(1'b0);
        branchProgram();
        callReturnProgram();
        loadStoreTest(1'b1);
        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/mipsPkg.sv
src/regFile.sv
src/alu.sv
src/instrDecoder.sv
src/cpuController.sv
src/mipsCpuBus.sv
tests/busMemory.sv
tests/tbMipsCpuBus.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsCpuBus
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Test completed successfully

.PHONY: all build run clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv) $(wildcard tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
